// File: all.f
verilog/cpuPkg.sv
verilog/runControl.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuTop.sv
verif/cpuTop_asserts.sv
verif/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module cpuTb \
    -f all.f \
    -o cpuSim

./obj_dir/cpuSim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: verif/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 8;
    localparam int PROG_MAX    = 60;    // longest body, halt excluded
    localparam int JUNK_WORDS  = 6;
    localparam int RUNS        = 3;
    localparam int CLK_NS      = 20;
    localparam int LOAD_MAX    = PROG_MAX + 1 + JUNK_WORDS;
    localparam longint WATCHDOG_NS =
        longint'(RUNS) * (LOAD_MAX + 4 * (PROG_MAX + 1) + 40) * CLK_NS;

    logic                   clk;
    logic                   rst;
    logic                   instWe;
    logic [IMEM_ADDR_W-1:0] instAddr;
    logic [DATA_W-1:0]      instData;
    logic                   start;
    wbPortS                 wb;
    logic                   memWe;
    logic [DMEM_ADDR_W-1:0] memAddr;
    logic [DATA_W-1:0]      memData;
    logic                   halted;

    integer seed;
    string  testName;
    logic   idle;       // between reset and start
    int     errCount;
    int     checkCount;
    int     bodyLen;

    logic [DATA_W-1:0]             prog [$];
    logic [DATA_W-1:0]             modelRegs [2**REG_ADDR_W];
    logic [DATA_W-1:0]             modelMem [2**DMEM_ADDR_W];  // kept across runs, as in the DUT
    logic [DMEM_ADDR_W-1:0]        knownAddr [$];              // words stored so far
    logic [REG_ADDR_W+DATA_W-1:0]  wbQ [$];
    logic [DMEM_ADDR_W+DATA_W-1:0] stQ [$];

    cpuTop #(
        .IMEM_ADDR_W    (IMEM_ADDR_W),
        .DMEM_ADDR_W    (DMEM_ADDR_W)
    ) u_cpuTop (
        .clk            (clk        ),
        .i_rst          (rst        ),
        .i_instWe       (instWe     ),
        .i_instAddr     (instAddr   ),
        .i_instData     (instData   ),
        .i_start        (start      ),
        .o_wb           (wb         ),
        .o_memWe        (memWe      ),
        .o_memAddr      (memAddr    ),
        .o_memData      (memData    ),
        .o_halted       (halted     )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ----------------------------------------------------------------------
    // program generation and reference model
    // ----------------------------------------------------------------------
    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [DATA_W-1:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {OP_RTYPE, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic logic [DATA_W-1:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic genProgram();
        int unsigned            kind;
        int                     n;
        int                     i;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        logic [5:0]             fn;
        logic [DMEM_ADDR_W-1:0] word;
        prog.delete();
        for (i = 1; i < 8; i++) begin   // give r1..r7 known values first
            prog.push_back(encI(OP_ADDI, 5'd0, REG_ADDR_W'(i), 16'($random(seed))));
        end
        n = 33 + int'(randBelow(21));
        for (i = 0; i < n; i++) begin
            kind = randBelow(10);
            rs   = REG_ADDR_W'(randBelow(8));
            rt   = REG_ADDR_W'(randBelow(8));
            rd   = REG_ADDR_W'(randBelow(8));
            if (kind < 4) begin
                case (randBelow(5))
                    0:       fn = FN_ADD;
                    1:       fn = FN_SUB;
                    2:       fn = FN_AND;
                    3:       fn = FN_OR;
                    default: fn = FN_SLT;
                endcase
                prog.push_back(encR(fn, rs, rt, rd));
            end else if (kind < 6) begin
                prog.push_back(encI(OP_ADDI, rs, rt, 16'($random(seed))));
            end else if (kind < 8 && knownAddr.size() > 0) begin
                // loads only from words already written
                word = knownAddr[randBelow(knownAddr.size())];
                prog.push_back(encI(OP_LW, 5'd0, rt, 16'({word, 2'b00})));
            end else begin
                word = DMEM_ADDR_W'(randBelow(2**DMEM_ADDR_W));
                knownAddr.push_back(word);
                prog.push_back(encI(OP_SW, 5'd0, rt, 16'({word, 2'b00})));
            end
        end
        bodyLen = prog.size();
        prog.push_back({OP_HALT, 26'b0});
        for (i = 0; i < JUNK_WORDS; i++) begin  // would show up as writes if they ran
            prog.push_back(encI(OP_ADDI, 5'd0, REG_ADDR_W'(1 + randBelow(7)),
                                16'($random(seed))));
        end
    endtask

    task automatic writeReg(input logic [REG_ADDR_W-1:0] idx, input logic [DATA_W-1:0] val);
        if (idx != '0) begin            // r0 stays zero and unreported
            modelRegs[idx] = val;
            wbQ.push_back({idx, val});
        end
    endtask

    task automatic runModel();
        logic [DATA_W-1:0]      ins;
        logic [DATA_W-1:0]      a;
        logic [DATA_W-1:0]      b;
        logic [DATA_W-1:0]      sum;
        logic [DMEM_ADDR_W-1:0] word;
        int                     i;
        wbQ.delete();
        stQ.delete();
        foreach (modelRegs[r]) begin
            modelRegs[r] = '0;
        end
        for (i = 0; i < bodyLen; i++) begin
            ins  = prog[i];
            a    = modelRegs[ins[25:21]];
            b    = modelRegs[ins[20:16]];
            sum  = a + {{16{ins[15]}}, ins[15:0]};
            word = sum[DMEM_ADDR_W+1:2];
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADD:  writeReg(ins[15:11], a + b);
                        FN_SUB:  writeReg(ins[15:11], a - b);
                        FN_AND:  writeReg(ins[15:11], a & b);
                        FN_OR:   writeReg(ins[15:11], a | b);
                        FN_SLT:  writeReg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                OP_ADDI: writeReg(ins[20:16], sum);
                OP_LW:   writeReg(ins[20:16], modelMem[word]);
                OP_SW: begin
                    modelMem[word] = b;
                    stQ.push_back({word, b});
                end
                default: ;
            endcase
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic resetDut();
        @(posedge clk);
        rst    <= 1'b1;
        start  <= 1'b0;
        instWe <= 1'b0;
        @(posedge clk);
        idle = 1'b1;                    // outputs are cleared from here on
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            instWe   <= 1'b1;
            instAddr <= IMEM_ADDR_W'(i);
            instData <= prog[i];
        end
        @(posedge clk);
        instWe <= 1'b0;
        start  <= 1'b1;
        idle = 1'b0;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // response checks
    // ----------------------------------------------------------------------
    task automatic checkWrite();
        logic [REG_ADDR_W+DATA_W-1:0] exp;
        assert (!halted) else begin
            $display("error %s: register write reported after halt", testName);
            errCount++;
        end
        assert (wbQ.size() > 0) else begin
            $display("error %s: unexpected write of r%0d = %h", testName, wb.addr, wb.data);
            errCount++;
        end
        if (wbQ.size() > 0) begin
            exp = wbQ.pop_front();
            checkCount++;
            assert ({wb.addr, wb.data} == exp) else begin
                $display("error %s write: expected r%0d = %h, actual r%0d = %h", testName,
                         exp[DATA_W+:REG_ADDR_W], exp[DATA_W-1:0], wb.addr, wb.data);
                errCount++;
            end
        end
    endtask

    task automatic checkStore();
        logic [DMEM_ADDR_W+DATA_W-1:0] exp;
        assert (!halted) else begin
            $display("error %s: store reported after halt", testName);
            errCount++;
        end
        assert (stQ.size() > 0) else begin
            $display("error %s: unexpected store of %h to word %h", testName, memData, memAddr);
            errCount++;
        end
        if (stQ.size() > 0) begin
            exp = stQ.pop_front();
            checkCount++;
            assert ({memAddr, memData} == exp) else begin
                $display("error %s store: expected [%h] = %h, actual [%h] = %h", testName,
                         exp[DATA_W+:DMEM_ADDR_W], exp[DATA_W-1:0], memAddr, memData);
                errCount++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (idle) begin
            assert (!halted && !wb.valid && !memWe) else begin
                $display("error %s: output active during reset or before start", testName);
                errCount++;
            end
        end else begin
            if (wb.valid) checkWrite();
            if (memWe) checkStore();
        end
    end

    // ----------------------------------------------------------------------
    // main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        instWe     = 1'b0;
        instAddr   = '0;
        instData   = '0;
        start      = 1'b0;
        idle       = 1'b1;
        errCount   = 0;
        checkCount = 0;
        seed       = 32'h4a743191;
        testName   = "init";
        for (int run = 0; run < RUNS; run++) begin
            testName = $sformatf("run%0d", run);
            genProgram();
            runModel();
            resetDut();
            loadProgram();
            while (!halted) @(negedge clk);
            assert (wbQ.size() == 0 && stQ.size() == 0) else begin
                $display("error %s: halted with %0d writes and %0d stores still expected",
                         testName, wbQ.size(), stQ.size());
                errCount++;
            end
            repeat (8) @(posedge clk);  // nothing may commit after halt
        end
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        errCount++;
        $display("error %s: pipeline hung, halt not reached in time", testName);
        $display("checks %0d, errors %0d", checkCount, errCount);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/cpuTop_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTopAsserts import cpuPkg::*; (
    input logic   clk,
    input logic   i_rst,
    input logic   i_halted,
    input wbPortS i_wb
);

    // ----------------------------------------------------------------------
    // run-level rules
    // ----------------------------------------------------------------------
    haltSticky: assert property (@(posedge clk) disable iff (i_rst) !$fell(i_halted))
        else $error("o_halted dropped without a reset");

    // pipeline is drained once halted
    noWbAfterHalt: assert property (@(posedge clk) disable iff (i_rst)
        i_halted |-> !i_wb.valid)
        else $error("register write reported while halted");

    noWbToR0: assert property (@(posedge clk) disable iff (i_rst)
        i_wb.valid |-> (i_wb.addr != '0))
        else $error("register write reported for r0");

endmodule

bind cpuTop cpuTopAsserts u_cpuTopAsserts (
    .clk        (clk     ),
    .i_rst      (i_rst   ),
    .i_halted   (o_halted),
    .i_wb       (o_wb    )
);

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // ----------------------------------------------------------------------
    // encodings
    // ----------------------------------------------------------------------
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F
    } opcodeE;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2A
    } functE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOpE;

    // operand source seen by execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSelE;

    typedef enum logic [1:0] {
        LOAD,
        RUN,
        DRAIN,
        HALTED
    } runStateE;

    // ----------------------------------------------------------------------
    // pipeline registers
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] instr;
    } ifIdS;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  useImm;
        logic                  halt;
        aluOpE                 aluOp;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     rsData;
        logic [DATA_W-1:0]     rtData;
        logic [DATA_W-1:0]     imm;    // already sign extended
    } idExS;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic                  halt;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;
        logic [DATA_W-1:0]     storeData;
    } exMemS;

    typedef struct packed {
        logic                  valid;
        logic                  regWrite;
        logic                  memRead;
        logic                  halt;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     result;
        logic [DATA_W-1:0]     loadData;
    } memWbS;

    // register write report, also the write-back bus into decode
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } wbPortS;

endpackage

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter int IMEM_ADDR_W = 8,
    parameter int DMEM_ADDR_W = 8
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_instWe,
    input  logic [IMEM_ADDR_W-1:0] i_instAddr,
    input  logic [DATA_W-1:0]      i_instData,
    input  logic                   i_start,
    output wbPortS                 o_wb,
    output logic                   o_memWe,
    output logic [DMEM_ADDR_W-1:0] o_memAddr,
    output logic [DATA_W-1:0]      o_memData,
    output logic                   o_halted
);

    logic  loadEn;
    logic  fetchEn;
    logic  stall;
    logic  haltSeen;
    logic  haltRetired;
    ifIdS  ifId;
    idExS  idEx;
    exMemS exMem;

    // ----------------------------------------------------------------------
    // run control
    // ----------------------------------------------------------------------
    runControl u_runControl (
        .clk            (clk        ),
        .i_rst          (i_rst      ),
        .i_start        (i_start    ),
        .i_haltSeen     (haltSeen   ),
        .i_haltRetired  (haltRetired),
        .o_loadEn       (loadEn     ),
        .o_fetchEn      (fetchEn    ),
        .o_halted       (o_halted   )
    );

    // ----------------------------------------------------------------------
    // pipeline stages
    // ----------------------------------------------------------------------
    fetchStage #(
        .IMEM_ADDR_W    (IMEM_ADDR_W)
    ) u_fetchStage (
        .clk            (clk        ),
        .i_rst          (i_rst      ),
        .i_loadEn       (loadEn     ),
        .i_instWe       (i_instWe   ),
        .i_instAddr     (i_instAddr ),
        .i_instData     (i_instData ),
        .i_fetchEn      (fetchEn    ),
        .i_stall        (stall      ),
        .o_ifId         (ifId       )
    );

    decodeStage u_decodeStage (
        .clk            (clk        ),
        .i_rst          (i_rst      ),
        .i_ifId         (ifId       ),
        .i_wb           (o_wb       ),  // write-back into the register file
        .o_idEx         (idEx       ),
        .o_stall        (stall      ),
        .o_haltSeen     (haltSeen   )
    );

    executeStage u_executeStage (
        .clk            (clk        ),
        .i_rst          (i_rst      ),
        .i_idEx         (idEx       ),
        .i_wb           (o_wb       ),  // MEM/WB forwarding source
        .o_exMem        (exMem      )
    );

    memoryStage #(
        .DMEM_ADDR_W    (DMEM_ADDR_W)
    ) u_memoryStage (
        .clk            (clk        ),
        .i_rst          (i_rst      ),
        .i_exMem        (exMem      ),
        .o_wb           (o_wb       ),
        .o_memWe        (o_memWe    ),
        .o_memAddr      (o_memAddr  ),
        .o_memData      (o_memData  ),
        .o_haltRetired  (haltRetired)
    );

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   i_rst,
    input  ifIdS   i_ifId,
    input  wbPortS i_wb,
    output idExS   o_idEx,
    output logic   o_stall,
    output logic   o_haltSeen
);

    logic [DATA_W-1:0]     regFile [2**REG_ADDR_W];
    opcodeE                opcode;
    functE                 funct;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_W-1:0]     rsData;
    logic [DATA_W-1:0]     rtData;
    logic                  functOk;
    aluOpE                 functAluOp;
    logic                  ctlRegWrite;
    logic                  ctlMemRead;
    logic                  ctlMemWrite;
    logic                  ctlUseImm;
    logic                  ctlHalt;
    aluOpE                 ctlAluOp;
    logic [REG_ADDR_W-1:0] ctlDest;
    logic                  loadHazard;
    idExS                  idEx;

    assign opcode = opcodeE'(i_ifId.instr[31:26]);
    assign funct  = functE'(i_ifId.instr[5:0]);
    assign rs     = i_ifId.instr[25:21];
    assign rt     = i_ifId.instr[20:16];
    assign rd     = i_ifId.instr[15:11];

    // ----------------------------------------------------------------------
    // register file, write before read
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_wb.valid) begin           // never names r0
            regFile[i_wb.addr] <= i_wb.data;
        end
    end

    assign rsData = (rs == '0) ? '0 :
                    (i_wb.valid && i_wb.addr == rs) ? i_wb.data : regFile[rs];
    assign rtData = (rt == '0) ? '0 :
                    (i_wb.valid && i_wb.addr == rt) ? i_wb.data : regFile[rt];

    // ----------------------------------------------------------------------
    // control decode
    // ----------------------------------------------------------------------
    always_comb begin
        functOk    = 1'b1;
        functAluOp = ALU_ADD;
        case (funct)
            FN_ADD:  functAluOp = ALU_ADD;
            FN_SUB:  functAluOp = ALU_SUB;
            FN_AND:  functAluOp = ALU_AND;
            FN_OR:   functAluOp = ALU_OR;
            FN_SLT:  functAluOp = ALU_SLT;
            default: functOk = 1'b0;    // unknown funct, no write
        endcase
    end

    always_comb begin
        ctlRegWrite = 1'b0;
        ctlMemRead  = 1'b0;
        ctlMemWrite = 1'b0;
        ctlUseImm   = 1'b0;
        ctlHalt     = 1'b0;
        ctlAluOp    = ALU_ADD;          // address add for lw and sw
        ctlDest     = rt;
        case (opcode)
            OP_RTYPE: begin
                ctlRegWrite = functOk;
                ctlAluOp    = functAluOp;
                ctlDest     = rd;
            end
            OP_ADDI: begin
                ctlRegWrite = 1'b1;
                ctlUseImm   = 1'b1;
            end
            OP_LW: begin
                ctlRegWrite = 1'b1;
                ctlMemRead  = 1'b1;
                ctlUseImm   = 1'b1;
            end
            OP_SW: begin
                ctlMemWrite = 1'b1;
                ctlUseImm   = 1'b1;
            end
            OP_HALT: ctlHalt = 1'b1;
            default: ctlHalt = 1'b0;    // decodes as a nop
        endcase
    end

    assign o_haltSeen = i_ifId.valid && ctlHalt;

    // load in ID/EX feeding the instruction now in IF/ID
    assign loadHazard = idEx.valid && idEx.memRead && (idEx.dest != '0) &&
                        ((idEx.dest == rs) || (idEx.dest == rt));
    assign o_stall    = i_ifId.valid && loadHazard;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            idEx.valid <= 1'b0;
        end else begin
            idEx.valid    <= i_ifId.valid && !o_stall;  // bubble on stall
            idEx.regWrite <= ctlRegWrite;
            idEx.memRead  <= ctlMemRead;
            idEx.memWrite <= ctlMemWrite;
            idEx.useImm   <= ctlUseImm;
            idEx.halt     <= ctlHalt;
            idEx.aluOp    <= ctlAluOp;
            idEx.rs       <= rs;
            idEx.rt       <= rt;
            idEx.dest     <= ctlDest;
            idEx.rsData   <= rsData;
            idEx.rtData   <= rtData;
            idEx.imm      <= {{(DATA_W-16){i_ifId.instr[15]}}, i_ifId.instr[15:0]};
        end
    end

    assign o_idEx = idEx;

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   i_rst,
    input  idExS   i_idEx,
    input  wbPortS i_wb,
    output exMemS  o_exMem
);

    fwdSelE            fwdA;
    fwdSelE            fwdB;
    logic [DATA_W-1:0] opA;
    logic [DATA_W-1:0] opBReg;  // forwarded rt, also the store data
    logic [DATA_W-1:0] opB;
    logic [DATA_W-1:0] aluResult;
    exMemS             exMem;

    // nearest older producer wins, r0 never forwarded
    function automatic fwdSelE pickFwd(input logic [REG_ADDR_W-1:0] src,
                                       input exMemS older,
                                       input wbPortS wb);
        if (older.valid && older.regWrite && older.dest != '0 && older.dest == src) begin
            return FWD_EXMEM;
        end else if (wb.valid && wb.addr == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    function automatic logic [DATA_W-1:0] selOperand(input fwdSelE sel,
                                                     input logic [DATA_W-1:0] regVal,
                                                     input logic [DATA_W-1:0] exMemVal,
                                                     input logic [DATA_W-1:0] wbVal);
        case (sel)
            FWD_EXMEM: return exMemVal;
            FWD_MEMWB: return wbVal;
            default:   return regVal;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // forwarding and ALU
    // ----------------------------------------------------------------------
    assign fwdA   = pickFwd(i_idEx.rs, exMem, i_wb);
    assign fwdB   = pickFwd(i_idEx.rt, exMem, i_wb);
    assign opA    = selOperand(fwdA, i_idEx.rsData, exMem.result, i_wb.data);
    assign opBReg = selOperand(fwdB, i_idEx.rtData, exMem.result, i_wb.data);
    assign opB    = i_idEx.useImm ? i_idEx.imm : opBReg;

    always_comb begin
        case (i_idEx.aluOp)
            ALU_ADD: aluResult = opA + opB;
            ALU_SUB: aluResult = opA - opB;
            ALU_AND: aluResult = opA & opB;
            ALU_OR:  aluResult = opA | opB;
            ALU_SLT: aluResult = {{(DATA_W-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluResult = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            exMem.valid <= 1'b0;
        end else begin
            exMem.valid     <= i_idEx.valid;
            exMem.regWrite  <= i_idEx.regWrite;
            exMem.memRead   <= i_idEx.memRead;
            exMem.memWrite  <= i_idEx.memWrite;
            exMem.halt      <= i_idEx.halt;
            exMem.dest      <= i_idEx.dest;
            exMem.result    <= aluResult;
            exMem.storeData <= opBReg;
        end
    end

    assign o_exMem = exMem;

endmodule

`default_nettype wire

// File: verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import cpuPkg::*; #(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_loadEn,
    input  logic                   i_instWe,
    input  logic [IMEM_ADDR_W-1:0] i_instAddr,
    input  logic [DATA_W-1:0]      i_instData,
    input  logic                   i_fetchEn,
    input  logic                   i_stall,
    output ifIdS                   o_ifId
);

    logic [DATA_W-1:0]      instMem [2**IMEM_ADDR_W];
    logic [IMEM_ADDR_W-1:0] pc;     // word address, wraps
    ifIdS                   ifId;

    // program load port, only open before the run
    always_ff @(posedge clk) begin
        if (i_loadEn && i_instWe) begin
            instMem[i_instAddr] <= i_instData;
        end
    end

    // ----------------------------------------------------------------------
    // program counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_fetchEn && !i_stall) begin
            pc <= pc + 1'b1;
        end
    end

    // IF/ID holds during a load-use stall
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ifId.valid <= 1'b0;
        end else if (!i_stall) begin
            ifId.valid <= i_fetchEn;    // bubble once fetch is off
            ifId.instr <= instMem[pc];
        end
    end

    assign o_ifId = ifId;

endmodule

`default_nettype wire

// File: verilog/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage import cpuPkg::*; #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  exMemS                  i_exMem,
    output wbPortS                 o_wb,
    output logic                   o_memWe,
    output logic [DMEM_ADDR_W-1:0] o_memAddr,
    output logic [DATA_W-1:0]      o_memData,
    output logic                   o_haltRetired
);

    logic [DATA_W-1:0]      dataMem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] memAddr;
    memWbS                  memWb;

    // word address from the byte address, wraps
    assign memAddr = i_exMem.result[DMEM_ADDR_W+1:2];

    assign o_memWe   = i_exMem.valid && i_exMem.memWrite;
    assign o_memAddr = memAddr;
    assign o_memData = i_exMem.storeData;

    always_ff @(posedge clk) begin
        if (o_memWe) begin
            dataMem[memAddr] <= i_exMem.storeData;
        end
    end

    // ----------------------------------------------------------------------
    // MEM/WB and write-back select
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            memWb.valid <= 1'b0;
        end else begin
            memWb.valid    <= i_exMem.valid;
            memWb.regWrite <= i_exMem.regWrite;
            memWb.memRead  <= i_exMem.memRead;
            memWb.halt     <= i_exMem.halt;
            memWb.dest     <= i_exMem.dest;
            memWb.result   <= i_exMem.result;
            memWb.loadData <= dataMem[memAddr];
        end
    end

    assign o_wb.valid    = memWb.valid && memWb.regWrite && (memWb.dest != '0);
    assign o_wb.addr     = memWb.dest;
    assign o_wb.data     = memWb.memRead ? memWb.loadData : memWb.result;
    assign o_haltRetired = memWb.valid && memWb.halt;

endmodule

`default_nettype wire

// File: verilog/runControl.sv
`timescale 1ns/1ps
`default_nettype none

module runControl import cpuPkg::*; (
    input  logic clk,
    input  logic i_rst,
    input  logic i_start,
    input  logic i_haltSeen,
    input  logic i_haltRetired,
    output logic o_loadEn,
    output logic o_fetchEn,
    output logic o_halted
);

    runStateE state;
    runStateE nextState;

    always_comb begin
        nextState = state;
        case (state)
            LOAD:    if (i_start) nextState = RUN;
            RUN:     if (i_haltSeen) nextState = DRAIN;
            DRAIN:   if (i_haltRetired) nextState = HALTED;
            HALTED:  nextState = HALTED;    // left only through reset
            default: nextState = LOAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= LOAD;
        end else begin
            state <= nextState;
        end
    end

    assign o_loadEn  = (state == LOAD);
    // fetch stops in the same cycle the halt shows up in decode
    assign o_fetchEn = (state == RUN) && !i_haltSeen;
    assign o_halted  = (state == HALTED);

endmodule

`default_nettype wire
